// File: src.f
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_ifs.sv
verilog/dual_port_ram.sv
verilog/page_mapper.sv
verilog/exec_core.sv
verilog/cpu_top.sv
verif/cpu_checker.sv
verif/tb_cpu.sv

// File: Makefile
TOP := tb_cpu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: verif/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module tb_cpu;

  localparam int num_tests    = 6;
  localparam int max_words    = 16;
  localparam int max_stores   = 4;
  localparam int cyc_per_inst = 12;
  localparam int clk_period   = 10;
  localparam int reset_cycles = 10;
  localparam int halt_limit   = (max_words / 2) * cyc_per_inst;  // cycles per program
  localparam int tail_cycles  = 3 * cyc_per_inst;  // covers the words that follow exit
  localparam int watchdog_ns  = num_tests * max_words * cyc_per_inst * clk_period
                                + num_tests * reset_cycles * clk_period;

  logic                   clka;
  logic                   rst;
  logic                   run;
  logic                   load_en;
  logic [`CPU_ADDR_W-1:0] load_addr;
  logic [`CPU_DATA_W-1:0] load_data;
  logic                   halted;
  logic                   st_valid;
  logic [`CPU_ADDR_W-1:0] st_addr;
  logic [`CPU_DATA_W-1:0] st_data;

  logic                                   test_start;
  logic                                   test_end;
  logic [8*12-1:0]                        cur_name;
  logic [2:0]                             cur_count;
  logic [max_stores-1:0][`CPU_ADDR_W-1:0] cur_addr;
  logic [max_stores-1:0][`CPU_DATA_W-1:0] cur_data;
  int                                     pass_count;
  int                                     fail_count;

  // word 2i holds {opcode, reg} and word 2i+1 the operand
  logic [8*12-1:0] names [0:num_tests-1] = '{
    "arith_stores", "page_ordered", "page_reusing",
    "load_restore", "jump_and_nop", "halt_and_rst"
  };
  logic [`CPU_DATA_W-1:0] progs [0:num_tests-1][0:max_words-1] = '{
    '{16'h0401, 16'hfff0, 16'h0501, 16'h0025, 16'h0601, 16'h0020, 16'h0301, 16'h0046,
      16'h1100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0402, 16'h1111, 16'h0302, 16'h00c8, 16'h0403, 16'h2222, 16'h0303, 16'h0046,
      16'h1100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0404, 16'h00a5, 16'h0304, 16'h0050, 16'h0504, 16'h0001, 16'h0304, 16'h0055,
      16'h0304, 16'h0102, 16'h1100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0401, 16'h1234, 16'h0301, 16'h0090, 16'h0205, 16'h0090, 16'h0505, 16'h0001,
      16'h0305, 16'h00c0, 16'h1100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0406, 16'h0055, 16'h0100, 16'h0006, 16'h0406, 16'h9999, 16'h2a06, 16'h7777,
      16'h0306, 16'h0040, 16'h1100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0301, 16'h0041, 16'h0305, 16'h0042, 16'h1100, 16'h0000, 16'h0402, 16'hbeef,
      16'h0302, 16'h0043, 16'h1100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
  };
  logic [2:0] counts [0:num_tests-1] = '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1, 3'd2};
  // physical address is new page * 64 + offset with pages handed out from 1
  logic [`CPU_ADDR_W-1:0] st_addrs [0:num_tests-1][0:max_stores-1] = '{
    '{10'd70, 10'd0, 10'd0, 10'd0},     // logical 70 to page 1
    '{10'd72, 10'd134, 10'd0, 10'd0},   // logical 200 first, then 70
    '{10'd80, 10'd85, 10'd130, 10'd0},  // page 1 reused and logical 258 to page 2
    '{10'd80, 10'd128, 10'd0, 10'd0},
    '{10'd64, 10'd0, 10'd0, 10'd0},
    '{10'd65, 10'd66, 10'd0, 10'd0}
  };
  logic [`CPU_DATA_W-1:0] st_datas [0:num_tests-1][0:max_stores-1] = '{
    '{16'hfff5, 16'h0000, 16'h0000, 16'h0000},  // fff0 + 25 - 20 with 16 bit wrap
    '{16'h1111, 16'h2222, 16'h0000, 16'h0000},
    '{16'h00a5, 16'h00a6, 16'h00a6, 16'h0000},
    '{16'h1234, 16'h1235, 16'h0000, 16'h0000},  // loaded value plus 1
    '{16'h0055, 16'h0000, 16'h0000, 16'h0000},  // skipped num2reg and no-op leave it
    '{16'h0000, 16'h0000, 16'h0000, 16'h0000}   // registers cleared by reset
  };

  cpu_top dut0 (
    .clka      (clka),
    .rst       (rst),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .halted    (halted),
    .st_valid  (st_valid),
    .st_addr   (st_addr),
    .st_data   (st_data)
  );

  cpu_checker #(.max_stores(max_stores)) chk0 (
    .clka       (clka),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .halted     (halted),
    .test_start (test_start),
    .test_end   (test_end),
    .test_name  (cur_name),
    .exp_count  (cur_count),
    .exp_addr   (cur_addr),
    .exp_data   (cur_data),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  initial begin
    clka = 1'b0;
    forever #(clk_period / 2) clka = ~clka;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before all tests finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clka);
    #1;
  endtask

  task automatic reset_dut();
    rst = 1'b0;
    repeat (reset_cycles) next_cycle();
    rst = 1'b1;
  endtask

  task automatic load_program(input int t);
    for (int w = 0; w < max_words; w++) begin
      load_en   = 1'b1;
      load_addr = w[`CPU_ADDR_W-1:0];
      load_data = progs[t][w];
      next_cycle();
    end
    load_en = 1'b0;
  endtask

  task automatic run_test(input int t);
    int waited;
    cur_name  = names[t];
    cur_count = counts[t];
    for (int j = 0; j < max_stores; j++) begin
      cur_addr[j] = st_addrs[t][j];
      cur_data[j] = st_datas[t][j];
    end
    reset_dut();
    load_program(t);
    test_start = 1'b1;
    run        = 1'b1;
    next_cycle();
    test_start = 1'b0;
    run        = 1'b0;
    waited     = 0;
    while (!halted && waited < halt_limit) begin
      next_cycle();
      waited++;
    end
    repeat (tail_cycles) next_cycle();  // a store after exit would show up here
    test_end = 1'b1;
    next_cycle();
    test_end = 1'b0;
  endtask

  initial begin
    rst        = 1'b0;
    run        = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    test_start = 1'b0;
    test_end   = 1'b0;
    cur_name   = '0;
    cur_count  = '0;
    cur_addr   = '0;
    cur_data   = '0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests run %0d, passed %0d, failed %0d", num_tests, pass_count, fail_count);
    if (fail_count == 0 && pass_count == num_tests) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_checker #(
  parameter int max_stores = 4
) (
  input  logic                                   clka,
  input  logic                                   st_valid,
  input  logic [`CPU_ADDR_W-1:0]                 st_addr,
  input  logic [`CPU_DATA_W-1:0]                 st_data,
  input  logic                                   halted,
  input  logic                                   test_start,  // clears the per-test state
  input  logic                                   test_end,    // closes the test
  input  logic [8*12-1:0]                        test_name,
  input  logic [2:0]                             exp_count,
  input  logic [max_stores-1:0][`CPU_ADDR_W-1:0] exp_addr,
  input  logic [max_stores-1:0][`CPU_DATA_W-1:0] exp_data,
  output int                                     pass_count,
  output int                                     fail_count
);

  int   seen;       // stores observed in this test
  int   errs;
  logic halt_flag;

  // sampled mid-cycle, when every output has settled
  initial begin
    pass_count = 0;
    fail_count = 0;
    seen       = 0;
    errs       = 0;
    halt_flag  = 1'b0;
    forever begin
      @(negedge clka);
      if (test_start) begin
        seen      = 0;
        errs      = 0;
        halt_flag = 1'b0;
      end
      if (st_valid) begin
        if (halt_flag) begin
          $display("test %s: a store appeared after the core halted", test_name);
          errs++;
        end else if (seen >= exp_count) begin
          $display("test %s: unexpected extra store to address %0d", test_name, st_addr);
          errs++;
        end else begin
          if (st_addr !== exp_addr[seen]) begin
            $display("MISMATCH test %s store %0d addr expected %0d actual %0d",
                     test_name, seen, exp_addr[seen], st_addr);
            errs++;
          end
          if (st_data !== exp_data[seen]) begin
            $display("MISMATCH test %s store %0d data expected %h actual %h",
                     test_name, seen, exp_data[seen], st_data);
            errs++;
          end
        end
        seen++;
      end
      if (halted) begin
        halt_flag = 1'b1;
      end
      if (test_end) begin
        if (!halt_flag) begin
          $display("test %s: halted never rose", test_name);
          errs++;
        end
        if (seen < exp_count) begin
          $display("test %s: only %0d of %0d stores were seen", test_name, seen, exp_count);
          errs++;
        end
        if (errs == 0) begin
          pass_count++;
          $display("test %s: passed with %0d stores", test_name, seen);
        end else begin
          fail_count++;
          $display("test %s: failed with %0d errors", test_name, errs);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_top (
  input  logic                   clka,
  input  logic                   rst,
  input  logic                   run,
  input  logic                   load_en,
  input  logic [`CPU_ADDR_W-1:0] load_addr,
  input  cpu_pkg::data_t         load_data,
  output logic                   halted,
  output logic                   st_valid,
  output logic [`CPU_ADDR_W-1:0] st_addr,
  output cpu_pkg::data_t         st_data
);

  mmu_if      mmu_bus ();
  ram_port_if ram_bus ();

  exec_core core0 (
    .clka   (clka),
    .rst    (rst),
    .run    (run),
    .halted (halted),
    .mmu    (mmu_bus.requester),
    .ram    (ram_bus.core)
  );

  page_mapper mapper0 (
    .clka (clka),
    .rst  (rst),
    .mmu  (mmu_bus.mapper)
  );

  dual_port_ram ram0 (
    .clka      (clka),
    .ram       (ram_bus.ram),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  // core write port seen from outside
  assign st_valid = ram_bus.wr_en;
  assign st_addr  = ram_bus.wr_addr;
  assign st_data  = ram_bus.wr_data;

endmodule

`default_nettype wire

// File: verilog/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module exec_core (
  input  logic      clka,
  input  logic      rst,
  input  logic      run,
  output logic      halted,
  mmu_if.requester  mmu,
  ram_port_if.core  ram
);
  import cpu_pkg::*;

  localparam int reg_idx_w = $clog2(`CPU_NUM_REGS);

  // steps of one memory access
  localparam logic [1:0] ph_req  = 2'd0;
  localparam logic [1:0] ph_wait = 2'd1;
  localparam logic [1:0] ph_data = 2'd2;

  core_stage_e            stage;
  logic [1:0]             phase;
  logic [`CPU_ADDR_W-1:0] pc;
  data_t                  regs [0:`CPU_NUM_REGS-1];
  logic [7:0]             inst_op;
  logic [reg_idx_w-1:0]   inst_reg;  // low bits of the register field
  data_t                  operand;
  logic                   mem_stage;
  log_addr_u              req_addr;

  always_comb begin
    case (stage)
      stg_fetch_arg:                 req_addr.raw = pc + 1'b1;  // second word
      stg_load_data, stg_store_data: req_addr.raw = operand[`CPU_ADDR_W-1:0];
      default:                       req_addr.raw = pc;
    endcase
  end

  assign mem_stage    = stage inside {stg_fetch_op, stg_fetch_arg, stg_load_data, stg_store_data};
  assign mmu.req      = mem_stage && (phase == ph_req);
  assign mmu.log_addr = req_addr;
  assign ram.rd_addr  = mmu.phys_addr;  // ram samples it in the done cycle
  assign halted       = (stage == stg_halted);

  always_ff @(posedge clka) begin
    if (!rst) begin
      stage     <= stg_idle;
      phase     <= ph_req;
      pc        <= '0;
      ram.wr_en <= 1'b0;
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ram.wr_en <= 1'b0;
      case (stage)
        stg_idle: begin
          if (run) begin
            pc    <= '0;
            phase <= ph_req;
            stage <= stg_fetch_op;
          end
        end
        stg_fetch_op, stg_fetch_arg, stg_load_data, stg_store_data: begin
          case (phase)
            ph_req:  phase <= ph_wait;
            ph_wait: begin
              if (mmu.done) begin
                phase     <= ph_data;
                ram.wr_en <= (stage == stg_store_data);  // store goes out now
              end
            end
            default: begin
              phase <= ph_req;
              case (stage)
                stg_fetch_op:  stage <= stg_fetch_arg;
                stg_fetch_arg: begin
                  pc    <= pc + 2'd2;
                  stage <= stg_decode;
                end
                stg_load_data: begin
                  regs[inst_reg] <= ram.rd_data;
                  stage          <= stg_fetch_op;
                end
                default:       stage <= stg_fetch_op;
              endcase
            end
          endcase
        end
        stg_decode: begin
          stage <= stg_fetch_op;
          case (inst_op)
            op_jmp:       pc <= operand[`CPU_ADDR_W-1:0];
            op_num2reg:   regs[inst_reg] <= operand;
            op_reg_plus:  regs[inst_reg] <= regs[inst_reg] + operand;  // wraps
            op_reg_minus: regs[inst_reg] <= regs[inst_reg] - operand;
            op_ram2reg:   stage <= stg_load_data;
            op_reg2ram:   stage <= stg_store_data;
            op_exit:      stage <= stg_halted;
            default:      ;  // unknown opcode skipped
          endcase
        end
        default: ;  // halted until reset
      endcase
    end
  end

  // instruction words and store payload
  always_ff @(posedge clka) begin
    if (stage == stg_fetch_op && phase == ph_data) begin
      inst_op  <= ram.rd_data[`CPU_DATA_W-1 -: 8];
      inst_reg <= ram.rd_data[reg_idx_w-1:0];
    end
    if (stage == stg_fetch_arg && phase == ph_data) begin
      operand <= ram.rd_data;
    end
    if (stage == stg_store_data && phase == ph_wait && mmu.done) begin
      ram.wr_addr <= mmu.phys_addr;
      ram.wr_data <= regs[inst_reg];
    end
  end

endmodule

`default_nettype wire

// File: verilog/page_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module page_mapper (
  input  logic   clka,
  input  logic   rst,
  mmu_if.mapper  mmu
);
  import cpu_pkg::*;

  localparam int num_pages = 1 << `CPU_PAGE_NUM_W;

  logic [`CPU_PAGE_NUM_W-1:0] ptab [0:num_pages-1];  // logical to physical page
  logic [num_pages-1:0]       pvalid;
  logic [`CPU_PAGE_NUM_W-1:0] next_free;             // next page to hand out
  logic                       miss_pend;             // table entry written last cycle
  logic                       hit;
  log_addr_u                  la;

  assign la  = mmu.log_addr;
  assign hit = pvalid[la.fields.page];

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < num_pages; i++) begin
        ptab[i] <= '0;
      end
      pvalid    <= {{(num_pages-1){1'b0}}, 1'b1};  // page 0 fixed to page 0
      next_free <= {{(`CPU_PAGE_NUM_W-1){1'b0}}, 1'b1};
      miss_pend <= 1'b0;
      mmu.done  <= 1'b0;
    end else begin
      mmu.done <= 1'b0;
      if (miss_pend) begin
        miss_pend <= 1'b0;
        mmu.done  <= 1'b1;  // second cycle of a miss
      end else if (mmu.req) begin
        if (hit) begin
          mmu.done <= 1'b1;
        end else begin
          // allocate on first touch
          ptab[la.fields.page]   <= next_free;
          pvalid[la.fields.page] <= 1'b1;
          next_free              <= next_free + 1'b1;
          miss_pend              <= 1'b1;
        end
      end
    end
  end

  // translated address, page joined to offset
  always_ff @(posedge clka) begin
    if (miss_pend || (mmu.req && hit)) begin
      mmu.phys_addr <= {ptab[la.fields.page], la.fields.offset};
    end
  end

endmodule

`default_nettype wire

// File: verilog/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module dual_port_ram (
  input  logic                   clka,
  ram_port_if.ram                ram,
  input  logic                   load_en,
  input  logic [`CPU_ADDR_W-1:0] load_addr,
  input  cpu_pkg::data_t         load_data
);
  import cpu_pkg::*;

  data_t mem [0:(1 << `CPU_ADDR_W)-1];

  // load port wins over the core write
  always_ff @(posedge clka) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  always_ff @(posedge clka) begin
    ram.rd_data <= mem[ram.rd_addr];  // registered read
  end

endmodule

`default_nettype wire

// File: verilog/cpu_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

interface mmu_if;
  import cpu_pkg::*;

  logic                   req;        // one cycle request
  log_addr_u              log_addr;   // held until done
  logic                   done;       // one cycle answer
  logic [`CPU_ADDR_W-1:0] phys_addr;  // valid with done

  modport requester (output req, output log_addr, input done, input phys_addr);
  modport mapper (input req, input log_addr, output done, output phys_addr);
endinterface

interface ram_port_if;
  import cpu_pkg::*;

  logic [`CPU_ADDR_W-1:0] rd_addr;
  data_t                  rd_data;  // one cycle after rd_addr
  logic                   wr_en;
  logic [`CPU_ADDR_W-1:0] wr_addr;
  data_t                  wr_data;

  modport core (output rd_addr, input rd_data, output wr_en, output wr_addr, output wr_data);
  modport ram (input rd_addr, output rd_data, input wr_en, input wr_addr, input wr_data);
endinterface

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] data_t;

  // opcode numbers kept from the original instruction set
  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17  // halt
  } opcode_e;

  typedef enum logic [3:0] {
    stg_idle,
    stg_fetch_op,
    stg_fetch_arg,
    stg_decode,
    stg_load_data,
    stg_store_data,
    stg_halted
  } core_stage_e;

  typedef struct packed {
    logic [`CPU_PAGE_NUM_W-1:0] page;
    logic [`CPU_PAGE_W-1:0]     offset;
  } log_fields_t;

  // logical address, flat for the core and split for the mapper
  typedef union packed {
    logic [`CPU_ADDR_W-1:0] raw;
    log_fields_t            fields;
  } log_addr_u;

endpackage

`default_nettype wire

// File: include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word width
`define CPU_DATA_W 16

// ram address width, 1024 words
`define CPU_ADDR_W 10

// offset bits inside a page, 64 words per page
`define CPU_PAGE_W 6

// page number bits, 16 pages
`define CPU_PAGE_NUM_W 4

// general purpose registers
`define CPU_NUM_REGS 8

`endif
